// File: Makefile
# Verilator flow for the matrix-multiply unit testbench

VERILATOR ?= verilator
TOP       ?= tb_matmul_unit
FILELIST  ?= tb.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLAGS     ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only when the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/mac_array.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module mac_array
    import matmul_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  logic          clear,
    input  operand_beat_t beat,
    output lane_vec_t     acc [`MAT_MUL_SIZE],
    output logic          compute_done
);

    localparam int N     = `MAT_MUL_SIZE;
    localparam int CNT_W = `LOG2_MAT_MUL_SIZE + 2;

    // Counter value in the cycle after cell (N-1,N-1) takes its last product
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(3 * N - 2);

    elem_t            a_pass [N][N-1];
    elem_t            b_pass [N-1][N];
    logic [CNT_W-1:0] tick;

    //////////////////////////////
    // Cell grid
    //////////////////////////////

    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            elem_t a_in;
            elem_t b_in;
            elem_t acc_q;

            // A enters from the left edge and B from the top edge
            if (j == 0) begin : g_a_edge
                assign a_in = beat.a_col[i];
            end else begin : g_a_link
                assign a_in = a_pass[i][j-1];
            end

            if (i == 0) begin : g_b_edge
                assign b_in = beat.b_row[j];
            end else begin : g_b_link
                assign b_in = b_pass[i-1][j];
            end

            // Sum is kept modulo 2^16 by the element width
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    acc_q <= '0;
                end else if (en) begin
                    if (clear) begin
                        acc_q <= '0;
                    end else begin
                        acc_q <= acc_q + a_in * b_in;
                    end
                end
            end

            if (j < N - 1) begin : g_a_fwd
                always_ff @(posedge clk) begin
                    if (!rst_n) begin
                        a_pass[i][j] <= '0;
                    end else if (en) begin
                        a_pass[i][j] <= a_in;
                    end
                end
            end

            if (i < N - 1) begin : g_b_fwd
                always_ff @(posedge clk) begin
                    if (!rst_n) begin
                        b_pass[i][j] <= '0;
                    end else if (en) begin
                        b_pass[i][j] <= b_in;
                    end
                end
            end

            assign acc[i][j] = acc_q;
        end
    end

    //////////////////////////////
    // Completion counter
    //////////////////////////////

    // Starts on the first valid beat and stops once the far corner is done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick <= '0;
        end else if (en) begin
            if (compute_done) begin
                tick <= '0;
            end else if (beat.valid || tick != '0) begin
                tick <= tick + 1'b1;
            end
        end
    end

    assign compute_done = (tick == LAST_TICK);

endmodule

// File: source/matmul_defines.svh
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

//////////////////////////////
// Array geometry
//////////////////////////////

// Matrix dimension, tied to the lane count of the vector processor
`define MAT_MUL_SIZE 8

// Width of the beat and row counters
`define LOG2_MAT_MUL_SIZE 3

// Element and accumulator width, products wrap modulo 2^16
`define DWIDTH 16

//////////////////////////////
// Vector pipeline control
//////////////////////////////

// One mask bit per row or column of an operand
`define MASK_WIDTH 8

`define REGIDWIDTH 8
`define NUMLANES 8

`endif

// File: source/matmul_pkg.sv
`include "matmul_defines.svh"

package matmul_pkg;

    //////////////////////////////
    // Elements and lane vectors
    //////////////////////////////

    // One matrix element, also used for every accumulator
    typedef logic [`DWIDTH-1:0] elem_t;

    // One value per lane, lane 0 in the low bits
    typedef elem_t [`MAT_MUL_SIZE-1:0] lane_vec_t;

    //////////////////////////////
    // Stage to stage beats
    //////////////////////////////

    // A column and B row after masking and skew
    // Lane i of both vectors is i cycles behind lane 0
    typedef struct packed {
        lane_vec_t a_col;
        lane_vec_t b_row;
        logic      valid;
    } operand_beat_t;

    // One row of the result matrix on its way out
    typedef struct packed {
        lane_vec_t                     data;
        logic [`LOG2_MAT_MUL_SIZE-1:0] row;
        logic                          valid;
    } result_row_t;

endpackage

// File: source/matmul_unit.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module matmul_unit
    import matmul_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          activate,
    input  lane_vec_t                     a_data,
    input  lane_vec_t                     b_data,
    input  valid_masks_t                  masks,
    input  logic [`REGIDWIDTH-1:0]        in_dst,
    input  logic                          in_dst_we,
    input  logic [`NUMLANES-1:0]          vmask,
    input  logic                          squash,
    output lane_vec_t                     c_data,
    output logic [`LOG2_MAT_MUL_SIZE-1:0] c_row,
    output logic                          c_valid,
    output logic                          stall,
    output logic [`REGIDWIDTH-1:0]        out_dst,
    output logic                          out_dst_we,
    output logic [`NUMLANES-1:0]          out_dst_mask
);

    logic          start;
    logic          compute_done;
    operand_beat_t beat;
    lane_vec_t     acc [`MAT_MUL_SIZE];
    result_row_t   row;
    wb_tag_t       tag_in;
    wb_tag_t       tag;

    // The one place where activate is accepted or dropped
    assign start  = activate & en & ~stall;
    assign tag_in = '{dst: in_dst, we: in_dst_we, mask: vmask};

    operand_skew i_skew (
        .clk(clk), .rst_n(rst_n), .en(en), .activate(start),
        .a_data(a_data), .b_data(b_data), .masks(masks),
        .beat(beat), .feeding()
    );

    mac_array i_array (
        .clk(clk), .rst_n(rst_n), .en(en), .clear(start),
        .beat(beat), .acc(acc), .compute_done(compute_done)
    );

    result_drain i_drain (
        .clk(clk), .rst_n(rst_n), .en(en), .activate(start),
        .compute_done(compute_done), .acc(acc), .row_out(row), .stall(stall)
    );

    wb_tag_track i_tag (
        .clk(clk), .rst_n(rst_n), .activate(start), .squash(squash),
        .stall(stall), .tag_in(tag_in), .tag_out(tag)
    );

    assign c_data       = row.data;
    assign c_row        = row.row;
    assign c_valid      = row.valid;
    assign out_dst      = tag.dst;
    assign out_dst_we   = tag.we & row.valid;
    assign out_dst_mask = tag.mask;

endmodule

// File: source/operand_skew.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module operand_skew
    import matmul_pkg::*;
    import vec_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  logic          activate,
    input  lane_vec_t     a_data,
    input  lane_vec_t     b_data,
    input  valid_masks_t  masks,
    output operand_beat_t beat,
    output logic          feeding
);

    logic [`LOG2_MAT_MUL_SIZE-1:0] beat_cnt;
    logic [`LOG2_MAT_MUL_SIZE-1:0] k;
    valid_masks_t                  masks_q;
    valid_masks_t                  masks_use;
    logic                          take;
    logic                          valid_q;
    lane_vec_t                     a_masked;
    lane_vec_t                     b_masked;

    // Beat 0 is taken in the activate cycle with the live masks
    assign take      = activate | feeding;
    assign k         = feeding ? beat_cnt : '0;
    assign masks_use = feeding ? masks_q : masks;

    always_comb begin
        for (int n = 0; n < `MAT_MUL_SIZE; n++) begin
            a_masked[n] = (take && masks_use.a_rows[n] && masks_use.a_cols[k])
                        ? a_data[n] : '0;
            b_masked[n] = (take && masks_use.b_cols[n] && masks_use.b_rows[k])
                        ? b_data[n] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && activate) begin
            masks_q <= masks;
        end
    end

    // Beats 1 to 7 follow activate in consecutive enabled cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feeding  <= 1'b0;
            beat_cnt <= '0;
            valid_q  <= 1'b0;
        end else if (en) begin
            valid_q <= take;
            if (activate) begin
                feeding  <= 1'b1;
                beat_cnt <= `LOG2_MAT_MUL_SIZE'(1);
            end else if (feeding) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (&beat_cnt) begin
                    feeding <= 1'b0;
                end
            end
        end
    end

    // Lane i sits behind i extra registers, which forms the diagonal wavefront
    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_lane
        elem_t a_dly [i+1];
        elem_t b_dly [i+1];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int d = 0; d <= i; d++) begin
                    a_dly[d] <= '0;
                    b_dly[d] <= '0;
                end
            end else if (en) begin
                a_dly[0] <= a_masked[i];
                b_dly[0] <= b_masked[i];
                for (int d = 1; d <= i; d++) begin
                    a_dly[d] <= a_dly[d-1];
                    b_dly[d] <= b_dly[d-1];
                end
            end
        end

        assign beat.a_col[i] = a_dly[i];
        assign beat.b_row[i] = b_dly[i];
    end

    assign beat.valid = valid_q;

endmodule

// File: source/result_drain.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module result_drain
    import matmul_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        activate,
    input  logic        compute_done,
    input  lane_vec_t   acc [`MAT_MUL_SIZE],
    output result_row_t row_out,
    output logic        stall
);

    lane_vec_t                     rows_q [`MAT_MUL_SIZE];
    logic [`LOG2_MAT_MUL_SIZE-1:0] row_cnt;
    logic                          draining;

    // Row 0 always sits at the head of the shift register
    always_ff @(posedge clk) begin
        if (en) begin
            if (compute_done) begin
                rows_q <= acc;
            end else if (draining) begin
                for (int r = 0; r < `MAT_MUL_SIZE - 1; r++) begin
                    rows_q[r] <= rows_q[r+1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            draining <= 1'b0;
            row_cnt  <= '0;
            stall    <= 1'b0;
        end else begin
            // activate arrives already qualified with en and stall
            if (activate) begin
                stall <= 1'b1;
            end
            if (en) begin
                if (compute_done) begin
                    draining <= 1'b1;
                    row_cnt  <= '0;
                end else if (draining) begin
                    row_cnt <= row_cnt + 1'b1;
                    // Last row leaves in this cycle, so stall drops after it
                    if (&row_cnt) begin
                        draining <= 1'b0;
                        stall    <= 1'b0;
                    end
                end
            end
        end
    end

    // A frozen cycle shows no row, so each row strobes exactly once
    assign row_out = '{data: rows_q[0], row: row_cnt, valid: draining & en};

endmodule

// File: source/vec_ctrl_pkg.sv
`include "matmul_defines.svh"

package vec_ctrl_pkg;

    // Writeback tag that travels with the instruction
    typedef struct packed {
        logic [`REGIDWIDTH-1:0] dst;
        logic                   we;
        logic [`NUMLANES-1:0]   mask;
    } wb_tag_t;

    // Operand validity masks, a clear bit turns the row or column into zeros
    typedef struct packed {
        logic [`MASK_WIDTH-1:0] a_rows;
        logic [`MASK_WIDTH-1:0] a_cols;
        logic [`MASK_WIDTH-1:0] b_rows;
        logic [`MASK_WIDTH-1:0] b_cols;
    } valid_masks_t;

endpackage

// File: source/wb_tag_track.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module wb_tag_track
    import vec_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    activate,
    input  logic    squash,
    input  logic    stall,
    input  wb_tag_t tag_in,
    output wb_tag_t tag_out
);

    wb_tag_t tag_q;

    //////////////////////////////
    // Tag capture and squash
    //////////////////////////////

    // Only one operation is in flight, so one copy of the tag is enough
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else if (activate) begin
            tag_q <= tag_in;
        end else if (squash && stall) begin
            // Cancelled writeback keeps its dst and lane mask, only we drops
            tag_q.we <= 1'b0;
        end
    end

    assign tag_out = tag_q;

endmodule

// File: tb.f
+incdir+source
source/matmul_pkg.sv
source/vec_ctrl_pkg.sv
source/operand_skew.sv
source/mac_array.sv
source/result_drain.sv
source/wb_tag_track.sv
source/matmul_unit.sv
verif/tb_matmul_unit.sv

// File: verif/tb_matmul_unit.sv
`timescale 1ns/1ps
`include "matmul_defines.svh"

module tb_matmul_unit
    import matmul_pkg::*;
    import vec_ctrl_pkg::*;
();

    localparam int N          = `MAT_MUL_SIZE;
    localparam int NUM_OPS    = 40;
    localparam int MAX_CYCLES = 4000;

    logic                          clk;
    logic                          rst_n;
    logic                          en;
    logic                          activate;
    logic                          squash;
    lane_vec_t                     a_data;
    lane_vec_t                     b_data;
    valid_masks_t                  masks;
    logic [`REGIDWIDTH-1:0]        in_dst;
    logic                          in_dst_we;
    logic [`NUMLANES-1:0]          vmask;
    lane_vec_t                     c_data;
    logic [`LOG2_MAT_MUL_SIZE-1:0] c_row;
    logic                          c_valid;
    logic                          stall;
    logic [`REGIDWIDTH-1:0]        out_dst;
    logic                          out_dst_we;
    logic [`NUMLANES-1:0]          out_dst_mask;

    int           seed         = 32'hd6a81550;
    int           cycles       = 0;
    int           rows_seen    = 0;
    int           ops_accepted = 0;
    int           squash_at;
    elem_t        a_mat [N][N];
    elem_t        b_mat [N][N];
    valid_masks_t cur_masks;
    wb_tag_t      cur_tag;
    lane_vec_t    exp_c [NUM_OPS*N];
    wb_tag_t      exp_tag [NUM_OPS];

    matmul_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("mismatch at time %0t: %s", $time, what));
    endtask

    function automatic elem_t rand_elem();
        return elem_t'($random(seed));
    endfunction

    function automatic lane_vec_t rand_lanes();
        lane_vec_t v;
        for (int i = 0; i < N; i++) begin
            v[i] = rand_elem();
        end
        return v;
    endfunction

    // En is low about a quarter of the time
    function automatic logic rand_en();
        return ($random(seed) & 3) != 0;
    endfunction

    // Roughly a quarter of the bits come out clear
    function automatic logic [`MASK_WIDTH-1:0] rand_mask();
        return ~(`MASK_WIDTH'($random(seed)) & `MASK_WIDTH'($random(seed)));
    endfunction

    function automatic lane_vec_t a_column(input int k);
        lane_vec_t v;
        for (int i = 0; i < N; i++) begin
            v[i] = a_mat[i][k];
        end
        return v;
    endfunction

    function automatic lane_vec_t b_row(input int k);
        lane_vec_t v;
        for (int j = 0; j < N; j++) begin
            v[j] = b_mat[k][j];
        end
        return v;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic build_operation(input int op);
        elem_t sum;
        logic  keep;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_mat[r][c] = rand_elem();
                b_mat[r][c] = rand_elem();
            end
        end
        cur_masks = '1;
        if (op >= 4 && op % 5 != 0) begin
            cur_masks.a_rows = rand_mask();
            cur_masks.a_cols = rand_mask();
            cur_masks.b_rows = rand_mask();
            cur_masks.b_cols = rand_mask();
        end
        // A masked element counts as zero, so its term drops out of the sum
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = '0;
                for (int k = 0; k < N; k++) begin
                    keep = cur_masks.a_rows[r] && cur_masks.a_cols[k]
                        && cur_masks.b_rows[k] && cur_masks.b_cols[c];
                    if (keep) begin
                        sum = sum + a_mat[r][k] * b_mat[k][c];
                    end
                end
                exp_c[op*N + r][c] = sum;
            end
        end
        cur_tag.dst  = `REGIDWIDTH'($random(seed));
        cur_tag.we   = 1'($random(seed));
        cur_tag.mask = `NUMLANES'($random(seed));
        squash_at    = (($random(seed) & 3) == 0) ? 1 + ($random(seed) & 3) : 0;
        exp_tag[op]    = cur_tag;
        exp_tag[op].we = cur_tag.we && squash_at == 0;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic issue_operation();
        int k;
        int iter;
        @(posedge clk);
        // Busy cycles carry a stray activate now and then, which must be dropped
        while (stall) begin
            activate <= !(c_valid && c_row == `LOG2_MAT_MUL_SIZE'(N-1))
                        && (($random(seed) & 7) == 0);
            en       <= rand_en();
            squash   <= 1'b0;
            a_data   <= rand_lanes();
            b_data   <= rand_lanes();
            @(posedge clk);
        end
        // Squash while idle is ignored
        activate  <= 1'b1;
        en        <= 1'b1;
        squash    <= 1'($random(seed));
        masks     <= cur_masks;
        in_dst    <= cur_tag.dst;
        in_dst_we <= cur_tag.we;
        vmask     <= cur_tag.mask;
        a_data    <= a_column(0);
        b_data    <= b_row(0);
        k = 1;
        iter = 0;
        while (k < N) begin
            @(posedge clk);
            iter++;
            activate  <= 1'b0;
            squash    <= (iter == squash_at);
            masks     <= valid_masks_t'($random(seed));
            in_dst    <= `REGIDWIDTH'($random(seed));
            in_dst_we <= 1'($random(seed));
            vmask     <= `NUMLANES'($random(seed));
            if (rand_en()) begin
                en     <= 1'b1;
                a_data <= a_column(k);
                b_data <= b_row(k);
                k++;
            end else begin
                en     <= 1'b0;
                a_data <= rand_lanes();
                b_data <= rand_lanes();
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && c_valid) begin
            rows_seen <= rows_seen + 1;
        end
        if (rst_n && activate && en && !stall) begin
            ops_accepted <= ops_accepted + 1;
        end
    end

    always @(posedge clk) begin
        if (cycles == MAX_CYCLES) begin
            stop_with_failure("timeout: the result rows did not all arrive in time");
        end
    end

    initial begin
        rst_n     = 1'b0;
        en        = 1'b0;
        activate  = 1'b0;
        squash    = 1'b0;
        a_data    = '0;
        b_data    = '0;
        masks     = '0;
        in_dst    = '0;
        in_dst_we = 1'b0;
        vmask     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) begin
            @(posedge clk);
            en     <= rand_en();
            squash <= 1'($random(seed));
            a_data <= rand_lanes();
        end
        for (int op = 0; op < NUM_OPS; op++) begin
            build_operation(op);
            issue_operation();
        end
        while (rows_seen < NUM_OPS * N) begin
            @(posedge clk);
            en <= rand_en();
        end
        repeat (2 * N) begin
            @(posedge clk);
            en <= 1'b1;
        end
        if (rows_seen == NUM_OPS * N && !stall) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_failure("run ended with extra rows or with stall still high");
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    row_data: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid |-> c_data == exp_c[rows_seen])
        else report_mismatch("result row data differs from the model");

    row_order: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid |-> c_row == `LOG2_MAT_MUL_SIZE'(rows_seen % N))
        else report_mismatch("result row index out of order");

    row_count: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid |-> rows_seen < ops_accepted * N)
        else report_mismatch("more than eight rows for one operation");

    tag_match: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid |-> out_dst == exp_tag[rows_seen / N].dst
                 && out_dst_mask == exp_tag[rows_seen / N].mask
                 && out_dst_we == exp_tag[rows_seen / N].we)
        else report_mismatch("writeback tag differs from the one taken at activate");

    we_qualified: assert property (@(posedge clk) disable iff (!rst_n)
        !c_valid |-> !out_dst_we)
        else report_mismatch("out_dst_we high without a result row");

    frozen_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !en |-> !c_valid)
        else report_mismatch("c_valid while en is low");

    idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        ops_accepted == 0 |-> !stall && !c_valid && !out_dst_we)
        else report_mismatch("outputs active before the first activate");

    stall_rise: assert property (@(posedge clk) disable iff (!rst_n)
        activate && en && !stall |=> stall)
        else report_mismatch("stall did not rise after an accepted activate");

    stall_fall: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid && c_row == `LOG2_MAT_MUL_SIZE'(N-1) |=> !stall)
        else report_mismatch("stall still high after the last row");

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !(c_valid && c_row == `LOG2_MAT_MUL_SIZE'(N-1)) |=> stall)
        else report_mismatch("stall dropped before the last row");

    stall_low: assert property (@(posedge clk) disable iff (!rst_n)
        !stall && !(activate && en) |=> !stall)
        else report_mismatch("stall rose without an accepted activate");

endmodule
